// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -Iinclude
TOP       = tb_board_io_top
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = run.log

.PHONY: compile run clean

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Result is taken from the log, not from the exit code
run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "Simulation incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: source/audio_mixer.sv
`timescale 1ns/1ns

module audio_mixer (
	input  logic                           FPGA_CLK2_50,
	input  logic                           BTN_RESET,
	input  board_io_pkg::audio_in_t        core_audio,
	input  logic [board_io_pkg::ATT_W-1:0] vol_att,
	output board_io_pkg::audio_pair_t      mixed
);

	localparam int W = board_io_pkg::AUDIO_W;

	// Right shift, arithmetic for signed samples
	function automatic logic [W-1:0] shr(
		input logic [W-1:0] v,
		input logic [3:0]   n,
		input logic         sgn
	);
		if (sgn)
			shr = $signed(v) >>> n;
		else
			shr = v >> n;
	endfunction

	// Crossfeed of one channel with the other
	function automatic logic [W-1:0] mix_ch(
		input logic [W-1:0] own,
		input logic [W-1:0] other,
		input logic [1:0]   mix,
		input logic         sgn
	);
		case (mix)
			2'd0: mix_ch = own;
			2'd1: mix_ch = own - shr(own, 4'd3, sgn) + shr(other, 4'd3, sgn);
			2'd2: mix_ch = own - shr(own, 4'd2, sgn) + shr(other, 4'd2, sgn);
			default: mix_ch = shr(own, 4'd1, sgn) + shr(other, 4'd1, sgn);
		endcase
	endfunction

	// ========================================================================
	// Stage 1, mix
	// ========================================================================

	logic [W-1:0] mix_l;
	logic [W-1:0] mix_r;
	logic         sgn_q;

	always_ff @(posedge FPGA_CLK2_50 or negedge BTN_RESET) begin
		if (!BTN_RESET) begin
			mix_l <= '0;
			mix_r <= '0;
			sgn_q <= 1'b0;
		end else begin
			mix_l <= mix_ch(core_audio.left, core_audio.right, core_audio.mix,
				core_audio.is_signed);
			mix_r <= mix_ch(core_audio.right, core_audio.left, core_audio.mix,
				core_audio.is_signed);
			// Signedness follows its sample into stage 2
			sgn_q <= core_audio.is_signed;
		end
	end

	// ========================================================================
	// Stage 2, attenuate
	// ========================================================================

	always_ff @(posedge FPGA_CLK2_50 or negedge BTN_RESET) begin
		if (!BTN_RESET) begin
			mixed <= '0;
		end else if (vol_att[board_io_pkg::ATT_W-1]) begin
			// Mute
			mixed <= '0;
		end else begin
			mixed.left  <= shr(mix_l, vol_att[3:0], sgn_q);
			mixed.right <= shr(mix_r, vol_att[3:0], sgn_q);
		end
	end

endmodule

// File: source/board_io_pkg.sv
package board_io_pkg;

	// ========================================================================
	// Board constants
	// ========================================================================

	// Core reset stretch, counted in FPGA_CLK2_50 cycles
	localparam int RESET_CNT_W = 7;
	localparam logic [RESET_CNT_W-1:0] RESET_HOLD_CYCLES = 7'd64;

	// Debounce sampling
	localparam int DEBOUNCE_TICK  = 8;
	localparam int DEBOUNCE_DEPTH = 8;
	localparam int DEBOUNCE_DIV_W = $clog2(DEBOUNCE_TICK);

	// Sync phase counter, saturating
	localparam int SYNC_CNT_W = 16;

	// Audio sample and attenuation widths
	localparam int AUDIO_W = 16;
	localparam int ATT_W   = 5;

	// Host command codes, low byte of the first word in a frame
	localparam logic [7:0] CMD_LED    = 8'h25;
	localparam logic [7:0] CMD_VOLUME = 8'h26;

	// ========================================================================
	// Bundles
	// ========================================================================

	// Host word channel, one word per strobe cycle
	typedef struct packed {
		logic        strobe;
		logic        uio;
		logic [15:0] din;
	} io_bus_t;

	// Core audio, mix selects crossfeed amount
	typedef struct packed {
		logic signed [AUDIO_W-1:0] left;
		logic signed [AUDIO_W-1:0] right;
		logic                      is_signed;
		logic [1:0]                mix;
	} audio_in_t;

	typedef struct packed {
		logic [AUDIO_W-1:0] left;
		logic [AUDIO_W-1:0] right;
	} audio_pair_t;

	// Per-bit LED override, high byte of the CMD_LED word
	typedef struct packed {
		logic [7:0] overtake;
		logic [7:0] state;
	} led_ctl_t;

	typedef struct packed {
		logic       user;
		logic [1:0] power;
		logic [1:0] disk;
	} led_status_t;

endpackage

// File: source/board_io_top.sv
`timescale 1ns/1ns

module board_io_top (
	input  logic                       FPGA_CLK2_50,
	input  logic                       BTN_RESET,
	input  logic                       btn_user,
	input  logic                       btn_osd,
	input  logic [1:0]                 key,
	input  board_io_pkg::io_bus_t      io,
	input  board_io_pkg::audio_in_t    core_audio,
	input  board_io_pkg::led_status_t  status,
	input  logic                       hs_in,
	input  logic                       vs_in,
	output logic                       core_reset_n,
	output logic [1:0]                 btn_state,
	output logic [7:0]                 led,
	output logic                       led_power,
	output logic                       led_user,
	output logic                       audio_l,
	output logic                       audio_r,
	output logic                       vga_hs,
	output logic                       vga_vs
);

	// ========================================================================
	// Reset, buttons, host channel
	// ========================================================================

	logic [board_io_pkg::ATT_W-1:0] vol_att;
	board_io_pkg::audio_pair_t      mixed;

	reset_stretch u_reset_stretch (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.BTN_RESET    (BTN_RESET),
		.core_reset_n (core_reset_n)
	);

	button_debounce u_button_debounce (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.BTN_RESET    (BTN_RESET),
		.btn_user     (btn_user),
		.btn_osd      (btn_osd),
		.key          (key),
		.btn_state    (btn_state)
	);

	io_cmd_decoder u_io_cmd_decoder (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.BTN_RESET    (BTN_RESET),
		.io           (io),
		.status       (status),
		.vol_att      (vol_att),
		.led          (led),
		.led_power    (led_power),
		.led_user     (led_user)
	);

	// ========================================================================
	// Audio path
	// ========================================================================

	audio_mixer u_audio_mixer (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.BTN_RESET    (BTN_RESET),
		.core_audio   (core_audio),
		.vol_att      (vol_att),
		.mixed        (mixed)
	);

	sigma_delta_dac dac_l (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.BTN_RESET    (BTN_RESET),
		.sample       (mixed.left),
		.is_signed    (core_audio.is_signed),
		.dac_out      (audio_l)
	);

	sigma_delta_dac dac_r (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.BTN_RESET    (BTN_RESET),
		.sample       (mixed.right),
		.is_signed    (core_audio.is_signed),
		.dac_out      (audio_r)
	);

	// Sync polarity, one per direction
	sync_polarity_fix sync_h (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.BTN_RESET    (BTN_RESET),
		.sync_in      (hs_in),
		.sync_out     (vga_hs)
	);

	sync_polarity_fix sync_v (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.BTN_RESET    (BTN_RESET),
		.sync_in      (vs_in),
		.sync_out     (vga_vs)
	);

endmodule

// File: source/button_debounce.sv
`timescale 1ns/1ns

module button_debounce (
	input  logic       FPGA_CLK2_50,
	input  logic       BTN_RESET,
	input  logic       btn_user,
	input  logic       btn_osd,
	input  logic [1:0] key,
	output logic [1:0] btn_state
);

	localparam int DEPTH = board_io_pkg::DEBOUNCE_DEPTH;

	logic [board_io_pkg::DEBOUNCE_DIV_W-1:0] div;
	logic                                    tick;
	logic [1:0]                              press;
	logic [1:0][DEPTH-1:0]                   hist;
	logic [1:0][DEPTH-1:0]                   next_hist;

	// Sample tick, free running
	assign tick = (div == board_io_pkg::DEBOUNCE_TICK - 1);

	always_ff @(posedge FPGA_CLK2_50 or negedge BTN_RESET) begin
		if (!BTN_RESET) begin
			div <= '0;
		end else begin
			div <= tick ? '0 : div + 1'b1;
		end
	end

	// Pins and keys are active low, either one counts as a press
	// Bit 1 user, bit 0 osd
	assign press[1] = ~(btn_user & key[1]);
	assign press[0] = ~(btn_osd & key[0]);

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			next_hist[i] = {hist[i][DEPTH-2:0], press[i]};
		end
	end

	// State flips only once the whole history agrees
	always_ff @(posedge FPGA_CLK2_50 or negedge BTN_RESET) begin
		if (!BTN_RESET) begin
			hist      <= '0;
			btn_state <= '0;
		end else if (tick) begin
			for (int i = 0; i < 2; i++) begin
				hist[i] <= next_hist[i];
				if (&next_hist[i])
					btn_state[i] <= 1'b1;
				else if (next_hist[i] == '0)
					btn_state[i] <= 1'b0;
			end
		end
	end

endmodule

// File: source/io_cmd_decoder.sv
`timescale 1ns/1ns

module io_cmd_decoder (
	input  logic                             FPGA_CLK2_50,
	input  logic                             BTN_RESET,
	input  board_io_pkg::io_bus_t            io,
	input  board_io_pkg::led_status_t        status,
	output logic [board_io_pkg::ATT_W-1:0]   vol_att,
	output logic [7:0]                       led,
	output logic                             led_power,
	output logic                             led_user
);

	// ========================================================================
	// Frame decode
	// ========================================================================

	logic                   has_cmd;
	logic [7:0]             cmd;
	board_io_pkg::led_ctl_t led_ctl;

	// First strobed word of a uio frame is the command,
	// all following words are its data
	always_ff @(posedge FPGA_CLK2_50 or negedge BTN_RESET) begin
		if (!BTN_RESET) begin
			has_cmd <= 1'b0;
			cmd     <= '0;
			led_ctl <= '0;
			vol_att <= '0;
		end else if (!io.uio) begin
			// Frame closed
			has_cmd <= 1'b0;
		end else if (io.strobe) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
				cmd     <= io.din[7:0];
			end else begin
				case (cmd)
					board_io_pkg::CMD_LED:
						led_ctl <= io.din;
					board_io_pkg::CMD_VOLUME:
						vol_att <= io.din[board_io_pkg::ATT_W-1:0];
					default: ;
				endcase
			end
		end
	end

	// ========================================================================
	// LED merge
	// ========================================================================

	logic [7:0] led_default;

	// Power LED blinks against power[0] only when power[1] enables it
	assign led_power = status.power[1] ? ~status.power[0] : 1'b0;
	assign led_user  = ~status.user;

	// Board pattern when the host does not own a bit
	// Bit 2 stays lit since the HDD LED is kept dark
	assign led_default = {3'b000, ~led_power, 1'b0, 1'b1, 1'b0, ~led_user};

	assign led = (led_ctl.overtake & led_ctl.state) | (~led_ctl.overtake & led_default);

endmodule

// File: source/reset_stretch.sv
`timescale 1ns/1ns

module reset_stretch (
	input  logic FPGA_CLK2_50,
	input  logic BTN_RESET,
	output logic core_reset_n
);

	// Remaining hold cycles, reloaded while the button is down
	logic [board_io_pkg::RESET_CNT_W-1:0] hold_cnt;

	always_ff @(posedge FPGA_CLK2_50 or negedge BTN_RESET) begin
		if (!BTN_RESET) begin
			hold_cnt <= board_io_pkg::RESET_HOLD_CYCLES;
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	// Core leaves reset on the edge that brings the count to zero
	assign core_reset_n = (hold_cnt == '0);

endmodule

// File: source/sigma_delta_dac.sv
`timescale 1ns/1ns

module sigma_delta_dac (
	input  logic                             FPGA_CLK2_50,
	input  logic                             BTN_RESET,
	input  logic [board_io_pkg::AUDIO_W-1:0] sample,
	input  logic                             is_signed,
	output logic                             dac_out
);

	localparam int W = board_io_pkg::AUDIO_W;

	logic [W-1:0] offset;
	logic [W:0]   acc;

	// Two's complement to offset binary, flip the MSB
	assign offset = {sample[W-1] ^ is_signed, sample[W-2:0]};

	// Carry out leaves the accumulator each cycle
	always_ff @(posedge FPGA_CLK2_50 or negedge BTN_RESET) begin
		if (!BTN_RESET) begin
			acc <= '0;
		end else begin
			acc <= {1'b0, acc[W-1:0]} + {1'b0, offset};
		end
	end

	// Carry bit is a flop output
	assign dac_out = acc[W];

endmodule

// File: source/sync_polarity_fix.sv
`timescale 1ns/1ns

module sync_polarity_fix (
	input  logic FPGA_CLK2_50,
	input  logic BTN_RESET,
	input  logic sync_in,
	output logic sync_out
);

	localparam int CW = board_io_pkg::SYNC_CNT_W;

	logic          s1, s2, s3;
	logic          rise, fall;
	logic [CW-1:0] cnt;
	logic [CW-1:0] high_len;
	logic [CW-1:0] low_len;
	logic          pol;

	// s1 and s2 synchronise, s3 is the edge reference
	assign rise = s2 & ~s3;
	assign fall = ~s2 & s3;

	always_ff @(posedge FPGA_CLK2_50 or negedge BTN_RESET) begin
		if (!BTN_RESET) begin
			s1       <= 1'b0;
			s2       <= 1'b0;
			s3       <= 1'b0;
			cnt      <= '0;
			high_len <= '0;
			low_len  <= '0;
			pol      <= 1'b0;
		end else begin
			s1 <= sync_in;
			s2 <= s1;
			s3 <= s2;
			// Phase length, restarted on each edge, sticks at full scale
			if (rise | fall)
				cnt <= '0;
			else if (cnt != '1)
				cnt <= cnt + 1'b1;
			if (fall)
				high_len <= cnt;
			if (rise)
				low_len <= cnt;
			pol <= (high_len > low_len);
		end
	end

	// Long-high form gets inverted so the pulse is the short phase
	assign sync_out = sync_in ^ pol;

endmodule

// File: verif/board_io_testdata.txt
# L cmd data status exp_led (hex) | B user osd key (hex) hold_clks (dec) exp_state (hex)
# A left right signed mix att exp_left exp_right (hex) | S sel high low exp_high (dec)
# LED frames, unknown command 31 must leave led alone
L 25 f0a5 10 a5
L 31 00ff 10 a5
L 25 0f00 0c 10
L 25 0000 08 04
L 25 ff3c 1f 3c
# Buttons, bit 1 user and bit 0 osd
B 1 1 3 100 0
B 0 1 3 96 2
B 1 1 3 40 2
B 0 1 3 96 2
B 1 1 2 96 1
B 1 0 3 30 1
B 1 1 3 24 1
B 1 1 3 96 0
# Audio through the DACs, constant input
A 8000 0800 0 1 02 1c40 05c0
A f000 2000 1 2 00 fc00 1400
A 4000 0000 1 3 01 1000 1000
# Sync, sel 0 is hs and 1 is vs
S 0 10 40 10
S 0 40 10 10
S 1 6 30 6
S 1 30 6 6

// File: include/audio_ref.svh
`ifndef AUDIO_REF_SVH
`define AUDIO_REF_SVH

// Sample widened to an integer with sign extension when signed
function automatic int extend_sample(
	input logic [board_io_pkg::AUDIO_W-1:0] v,
	input logic                             sgn
);
	if (sgn)
		extend_sample = int'($signed(v));
	else
		extend_sample = int'(v);
endfunction

// Floor of the sample divided by 2**k
function automatic int fraction(
	input logic [board_io_pkg::AUDIO_W-1:0] v,
	input int unsigned                      k,
	input logic                             sgn
);
	fraction = extend_sample(v, sgn) >>> k;
endfunction

// Stage 1 crossfeed wrapping at 16 bits
function automatic logic [board_io_pkg::AUDIO_W-1:0] crossfeed_mix(
	input logic [board_io_pkg::AUDIO_W-1:0] own,
	input logic [board_io_pkg::AUDIO_W-1:0] other,
	input logic [1:0]                       mix,
	input logic                             sgn
);
	int base;
	int sum;
	base = extend_sample(own, sgn);
	case (mix)
		2'd0: sum = base;
		2'd1: sum = base - fraction(own, 3, sgn) + fraction(other, 3, sgn);
		2'd2: sum = base - fraction(own, 2, sgn) + fraction(other, 2, sgn);
		default: sum = fraction(own, 1, sgn) + fraction(other, 1, sgn);
	endcase
	crossfeed_mix = sum[board_io_pkg::AUDIO_W-1:0];
endfunction

// Stage 2 where the top bit mutes
function automatic logic [board_io_pkg::AUDIO_W-1:0] attenuate(
	input logic [board_io_pkg::AUDIO_W-1:0] v,
	input logic [board_io_pkg::ATT_W-1:0]   att,
	input logic                             sgn
);
	int scaled;
	scaled = fraction(v, att[3:0], sgn);
	if (att[board_io_pkg::ATT_W-1])
		attenuate = '0;
	else
		attenuate = scaled[board_io_pkg::AUDIO_W-1:0];
endfunction

// Ones per 65536 DAC clocks equal the offset binary value
function automatic int unsigned dac_ones(
	input logic [board_io_pkg::AUDIO_W-1:0] v,
	input logic                             sgn
);
	dac_ones = extend_sample(v, sgn) + (sgn ? 32768 : 0);
endfunction

`endif

// File: verif/tb_board_io_top.sv
`timescale 1ns/1ns

module tb_board_io_top;

	`include "audio_ref.svh"

	// ========================================================================
	// Run length
	// ========================================================================

	// Ones are counted over a full accumulator wrap
	localparam int DAC_WINDOW     = 65536;
	// Constant-input DAC vectors in the data file
	localparam int AUDIO_VECTORS  = 3;
	// Reset, frames, buttons, sync waves and random sweep
	localparam int MISC_CYCLES    = 2500;
	localparam int TEST_CYCLES    = AUDIO_VECTORS * (DAC_WINDOW + 16) + MISC_CYCLES;
	localparam int TIMEOUT_CYCLES = TEST_CYCLES * 3 / 2;
	// Worst case debounce latency
	localparam int BTN_BOUND      = (board_io_pkg::DEBOUNCE_DEPTH + 1) *
		board_io_pkg::DEBOUNCE_TICK;
	localparam int SWEEP_LEN      = 48;

	logic                      FPGA_CLK2_50;
	logic                      BTN_RESET;
	logic                      btn_user;
	logic                      btn_osd;
	logic [1:0]                key;
	board_io_pkg::io_bus_t     io;
	board_io_pkg::audio_in_t   core_audio;
	board_io_pkg::led_status_t status;
	logic                      hs_in;
	logic                      vs_in;
	logic                      core_reset_n;
	logic [1:0]                btn_state;
	logic [7:0]                led;
	logic                      led_power;
	logic                      led_user;
	logic                      audio_l;
	logic                      audio_r;
	logic                      vga_hs;
	logic                      vga_vs;
	int                        cycle_cnt = 0;

	board_io_top dut0 (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.BTN_RESET    (BTN_RESET),
		.btn_user     (btn_user),
		.btn_osd      (btn_osd),
		.key          (key),
		.io           (io),
		.core_audio   (core_audio),
		.status       (status),
		.hs_in        (hs_in),
		.vs_in        (vs_in),
		.core_reset_n (core_reset_n),
		.btn_state    (btn_state),
		.led          (led),
		.led_power    (led_power),
		.led_user     (led_user),
		.audio_l      (audio_l),
		.audio_r      (audio_r),
		.vga_hs       (vga_hs),
		.vga_vs       (vga_vs)
	);

	// 100 ns period
	initial FPGA_CLK2_50 = 1'b0;
	always #50 FPGA_CLK2_50 = ~FPGA_CLK2_50;

	// Watchdog
	always @(posedge FPGA_CLK2_50) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
			stop_on_error($sformatf("Timeout: run did not finish within %0d clock cycles",
				TIMEOUT_CYCLES));
	end

	// ========================================================================
	// Helpers
	// ========================================================================

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic expect_equal(input string name, input int unsigned exp,
		input int unsigned act);
		assert (act == exp) else
			stop_on_error($sformatf("CHECK FAILED at %0t ns: %s expected 0x%0h, got 0x%0h",
				$time, name, exp, act));
	endtask

	// DAC ones count with one count of slack
	task automatic ones_within_tolerance(input string name, input int exp, input int act);
		assert (act >= exp - 1 && act <= exp + 1) else
			stop_on_error($sformatf("CHECK FAILED at %0t ns: %s ones expected %0d, got %0d",
				$time, name, exp, act));
	endtask

	// Inputs change 10 ns after the rising edge
	task automatic next_slot();
		@(posedge FPGA_CLK2_50);
		#10;
	endtask

	// Command word then one data word before uio drops
	task automatic send_frame(input logic [7:0] cmd, input logic [15:0] data);
		next_slot();
		io.uio    = 1'b1;
		io.strobe = 1'b1;
		io.din    = {8'h00, cmd};
		next_slot();
		io.din    = data;
		next_slot();
		io.strobe = 1'b0;
		io.uio    = 1'b0;
		io.din    = '0;
		next_slot();
	endtask

	// ========================================================================
	// Test steps
	// ========================================================================

	task automatic verify_reset();
		next_slot();
		@(negedge FPGA_CLK2_50);
		expect_equal("core_reset_n", 0, 32'(core_reset_n));
		next_slot();
		BTN_RESET = 1'b1;
		// Rises on the 64th edge after release
		for (int k = 0; k <= 64; k++) begin
			@(negedge FPGA_CLK2_50);
			expect_equal("core_reset_n", (k == 64) ? 1 : 0, 32'(core_reset_n));
		end
	endtask

	task automatic led_merge(input logic [7:0] cmd, input logic [15:0] data,
		input logic [4:0] st, input logic [7:0] exp_led);
		logic exp_power;
		logic exp_user;
		// Status bits are user, power[1], power[0], disk[1], disk[0]
		exp_power = st[3] & ~st[2];
		exp_user  = ~st[4];
		next_slot();
		status = st;
		send_frame(cmd, data);
		@(negedge FPGA_CLK2_50);
		expect_equal("led", 32'(exp_led), 32'(led));
		expect_equal("led_power", 32'(exp_power), 32'(led_power));
		expect_equal("led_user", 32'(exp_user), 32'(led_user));
	endtask

	task automatic button_script(input logic user_pin, input logic osd_pin,
		input logic [1:0] key_val, input int hold, input logic [1:0] exp_state);
		logic [1:0] settled;
		next_slot();
		btn_user = user_pin;
		btn_osd  = osd_pin;
		key      = key_val;
		// Bits already at target may never move
		settled  = ~(btn_state ^ exp_state);
		for (int c = 1; c <= hold; c++) begin
			@(negedge FPGA_CLK2_50);
			for (int b = 0; b < 2; b++) begin
				if (settled[b])
					expect_equal($sformatf("btn_state[%0d]", b), 32'(exp_state[b]),
						32'(btn_state[b]));
				else if (btn_state[b] == exp_state[b])
					settled[b] = 1'b1;
			end
			if (c > BTN_BOUND)
				expect_equal("btn_state", 32'(exp_state), 32'(btn_state));
		end
	endtask

	task automatic dac_vector(input logic [15:0] l, input logic [15:0] r, input logic sgn,
		input logic [1:0] mix, input logic [4:0] att, input logic [15:0] exp_l,
		input logic [15:0] exp_r);
		logic [15:0] ref_l;
		logic [15:0] ref_r;
		int          ones_l;
		int          ones_r;
		ref_l = attenuate(crossfeed_mix(l, r, mix, sgn), att, sgn);
		ref_r = attenuate(crossfeed_mix(r, l, mix, sgn), att, sgn);
		expect_equal("reference left sample", 32'(exp_l), 32'(ref_l));
		expect_equal("reference right sample", 32'(exp_r), 32'(ref_r));
		send_frame(board_io_pkg::CMD_VOLUME, {11'd0, att});
		core_audio.left      = l;
		core_audio.right     = r;
		core_audio.is_signed = sgn;
		core_audio.mix       = mix;
		// Two mixer stages plus a little settling
		repeat (4) next_slot();
		ones_l = 0;
		ones_r = 0;
		for (int i = 0; i < DAC_WINDOW; i++) begin
			@(negedge FPGA_CLK2_50);
			ones_l += int'(audio_l);
			ones_r += int'(audio_r);
		end
		ones_within_tolerance("audio_l", int'(dac_ones(exp_l, sgn)), ones_l);
		ones_within_tolerance("audio_r", int'(dac_ones(exp_r, sgn)), ones_r);
	endtask

	// Four periods with the output measured over the last one
	task automatic sync_wave(input logic sel, input int high, input int low,
		input int exp_high);
		int seen;
		seen = 0;
		for (int p = 0; p < 4; p++) begin
			for (int c = 0; c < high + low; c++) begin
				next_slot();
				if (sel)
					vs_in = (c < high);
				else
					hs_in = (c < high);
				@(negedge FPGA_CLK2_50);
				if (p == 3)
					seen += int'(sel ? vga_vs : vga_hs);
			end
		end
		expect_equal(sel ? "vga_vs high cycles" : "vga_hs high cycles", exp_high, seen);
	endtask

	// Random samples every cycle with the mixer output checked 2 cycles on
	task automatic mixer_sweep(input logic [4:0] att);
		logic [31:0] exp_q[$];
		logic [31:0] rnd;
		logic [31:0] ctl;
		logic [15:0] mix_l;
		logic [15:0] mix_r;
		send_frame(board_io_pkg::CMD_VOLUME, {11'd0, att});
		for (int i = 0; i < SWEEP_LEN + 2; i++) begin
			if (i < SWEEP_LEN) begin
				rnd = $urandom;
				ctl = $urandom;
				core_audio.left      = rnd[15:0];
				core_audio.right     = rnd[31:16];
				core_audio.is_signed = ctl[0];
				core_audio.mix       = ctl[2:1];
				mix_l = crossfeed_mix(rnd[15:0], rnd[31:16], ctl[2:1], ctl[0]);
				mix_r = crossfeed_mix(rnd[31:16], rnd[15:0], ctl[2:1], ctl[0]);
				exp_q.push_back({attenuate(mix_l, att, ctl[0]), attenuate(mix_r, att, ctl[0])});
			end
			@(negedge FPGA_CLK2_50);
			if (i >= 2)
				expect_equal("mixed", exp_q.pop_front(), 32'(dut0.mixed));
			next_slot();
		end
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================

	initial begin
		int         fd;
		int         c;
		int         n;
		int         f[7];
		logic [7:0] tag;
		BTN_RESET  = 1'b0;
		btn_user   = 1'b1;
		btn_osd    = 1'b1;
		key        = 2'b11;
		io         = '0;
		core_audio = '0;
		status     = '0;
		hs_in      = 1'b0;
		vs_in      = 1'b0;
		void'($urandom(29));
		fd = $fopen("verif/board_io_testdata.txt", "r");
		if (fd == 0)
			stop_on_error("Could not open the test data file verif/board_io_testdata.txt");
		verify_reset();
		// One tag character followed by its fields
		c = $fgetc(fd);
		while (c != -1) begin
			tag = c[7:0];
			case (tag)
				"#": begin
					while (c != -1 && c != 10)
						c = $fgetc(fd);
				end
				"L": begin
					n = $fscanf(fd, " %h %h %h %h", f[0], f[1], f[2], f[3]);
					if (n != 4)
						stop_on_error("Malformed LED line in the test data file");
					led_merge(f[0][7:0], f[1][15:0], f[2][4:0], f[3][7:0]);
				end
				"B": begin
					n = $fscanf(fd, " %h %h %h %d %h", f[0], f[1], f[2], f[3], f[4]);
					if (n != 5)
						stop_on_error("Malformed button line in the test data file");
					button_script(f[0][0], f[1][0], f[2][1:0], f[3], f[4][1:0]);
				end
				"A": begin
					n = $fscanf(fd, " %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4],
						f[5], f[6]);
					if (n != 7)
						stop_on_error("Malformed audio line in the test data file");
					dac_vector(f[0][15:0], f[1][15:0], f[2][0], f[3][1:0], f[4][4:0],
						f[5][15:0], f[6][15:0]);
				end
				"S": begin
					n = $fscanf(fd, " %d %d %d %d", f[0], f[1], f[2], f[3]);
					if (n != 4)
						stop_on_error("Malformed sync line in the test data file");
					sync_wave(f[0][0], f[1], f[2], f[3]);
				end
				" ", "\t", "\r", "\n": ;
				default:
					stop_on_error("Unknown operation tag in the test data file");
			endcase
			c = $fgetc(fd);
		end
		$fclose(fd);
		// Plain, shifted, deepest shift, muted
		mixer_sweep(5'h00);
		mixer_sweep(5'h03);
		mixer_sweep(5'h0f);
		mixer_sweep(5'h10);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+include
source/board_io_pkg.sv
source/reset_stretch.sv
source/button_debounce.sv
source/io_cmd_decoder.sv
source/audio_mixer.sv
source/sigma_delta_dac.sv
source/sync_polarity_fix.sv
source/board_io_top.sv
verif/tb_board_io_top.sv
